/* mul_cases.txt */
# a        b        hi       lo   (hex, hi:lo is the 64-bit product of a and b)
# each row is also run swapped as b times a with the same hi and lo
00000000 12345678 00000000 00000000
9abcdef0 00000000 00000000 00000000
ffffffff 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000001 deadbeef 00000000 deadbeef
cafef00d 00000001 00000000 cafef00d
00000001 00000001 00000000 00000001
ffffffff 00000001 00000000 ffffffff
00000001 80000000 00000000 80000000
ffffffff ffffffff fffffffe 00000001
fffffffe fffffffe fffffffc 00000004
7fffffff 7fffffff 3fffffff 00000001
80000001 80000001 40000001 00000001
80000000 80000000 40000000 00000000
10000000 10000000 01000000 00000000
00000002 00000004 00000000 00000008
00000020 00000040 00000000 00000800
00000100 00000100 00000000 00010000
00010000 00010000 00000001 00000000
80000000 00000002 00000001 00000000
00000100 01000000 00000001 00000000
40000000 00000004 00000001 00000000
00008000 00020000 00000001 00000000
ffffffff 00000002 00000001 fffffffe
ffffffff 80000000 7fffffff 80000000
ffffffff 00010000 0000ffff ffff0000
0000ffff ffffffff 0000fffe ffff0001
0000ffff 0000ffff 00000000 fffe0001
ffff0000 ffff0000 fffe0001 00000000
00010001 00010001 00000001 00020001
12345678 00000010 00000001 23456780
00000003 55555555 00000000 ffffffff
aaaaaaaa 00000003 00000001 fffffffe
0000000f 00000011 00000000 000000ff
00000003 00000005 00000000 0000000f
00000007 00000007 00000000 00000031

/* project.f */
+incdir+.
mul_pkg.sv
operand_capture.sv
dadda_stage.sv
dadda_tree.sv
product_adder.sv
mul_top.sv
tb_mul_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mul_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    // value mismatches over the whole run
    int error_count = 0;

    // one 32-bit word of the product, hi or lo
    task automatic check_half(
        input string             name,
        input mul_pkg::operand_t expected,
        input mul_pkg::operand_t actual
    );
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] t=%0t %s: expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // the whole 64-bit word rebuilt from hi and lo
    task automatic check_product(
        input mul_pkg::product_u expected,
        input mul_pkg::product_u actual
    );
        if (actual.full !== expected.full)
        begin
            error_count++;
            $display("[ERROR] t=%0t product: expected %h, got %h",
                     $time, expected.full, actual.full);
        end
    endtask

`endif

/* tb_mul_top.sv */
`timescale 1ns/1ps

module tb_mul_top;

    typedef struct packed
    {
        mul_pkg::operand_t a;
        mul_pkg::operand_t b;
        mul_pkg::operand_t hi;
        mul_pkg::operand_t lo;
        logic [1:0]        kind;
        int                issue;
    } case_t;

    logic              clk;
    logic              rst_n;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    mul_pkg::operand_t hi;
    mul_pkg::operand_t lo;

    case_t stim_q [$];
    case_t pending_q [$];
    case_t cur;
    int    cycle = 0;
    int    cycle_limit = 20;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    issued = 0;
    int    done_count = 0;

    `include "tb_checks.svh"

    mul_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .b     (b),
        .hi    (hi),
        .lo    (lo)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > cycle_limit)
        begin
            $display("timeout: run still busy after %0d cycles", cycle);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic string kind_name(logic [1:0] kind);
        case (kind)
            2'd0: return "file";
            2'd1: return "swap";
            default: return "rand";
        endcase
    endfunction

    // rows are a b hi lo in hex, each also queued as b*a
    task automatic load_cases();
        int                fd;
        int                got;
        string             line;
        case_t             c;
        mul_pkg::operand_t va;
        mul_pkg::operand_t vb;
        mul_pkg::operand_t vhi;
        mul_pkg::operand_t vlo;
        fd = $fopen("mul_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open mul_cases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                got = $fgets(line, fd);
                if (got > 0 && line.getc(0) != 8'h23)
                begin
                    got = $sscanf(line, "%h %h %h %h", va, vb, vhi, vlo);
                    if (got == 4)
                    begin
                        c = '0;
                        c.a = va;
                        c.b = vb;
                        c.hi = vhi;
                        c.lo = vlo;
                        c.kind = 2'd0;
                        stim_q.push_back(c);
                        c.a = vb;
                        c.b = va;
                        c.kind = 2'd1;
                        stim_q.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic add_random(int count);
        case_t             c;
        logic [63:0]       wa;
        logic [63:0]       wb;
        mul_pkg::product_u p;
        for (int i = 0; i < count; i++)
        begin
            c = '0;
            c.a = $urandom();
            c.b = $urandom();
            wa = {32'b0, c.a};
            wb = {32'b0, c.b};
            p.full = wa * wb;
            c.hi = p.half[1];
            c.lo = p.half[0];
            c.kind = 2'd2;
            stim_q.push_back(c);
        end
    endtask

    task automatic finish_case(case_t c, int n);
        mul_pkg::product_u exp_p;
        mul_pkg::product_u got_p;
        int                errs_before;
        errs_before = error_count;
        exp_p.half[1] = c.hi;
        exp_p.half[0] = c.lo;
        got_p.half[1] = hi;
        got_p.half[0] = lo;
        check_half("hi", c.hi, hi);
        check_half("lo", c.lo, lo);
        check_product(exp_p, got_p);
        if (error_count == errs_before)
        begin
            tests_passed++;
            $display("case %0d %s a=%h b=%h ok", n, kind_name(c.kind), c.a, c.b);
        end
        else
        begin
            tests_failed++;
            $display("case %0d %s a=%h b=%h FAIL", n, kind_name(c.kind), c.a, c.b);
        end
    endtask

    initial
    begin
        rst_n = 1'b0;
        // busy operands through reset so only the register clears keep hi and lo at zero
        a = '1;
        b = '1;
        void'($urandom(19751));
        load_cases();
        if (stim_q.size() == 0)
        begin
            $display("mul_cases.txt held no usable rows");
            tests_failed++;
        end
        add_random(200);
        cycle_limit = 2 * stim_q.size() + 20;

        // hi and lo stay zero through reset and the first edge after it
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_half("hi", '0, hi);
            check_half("lo", '0, lo);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_half("hi", '0, hi);
        check_half("lo", '0, lo);
        if (error_count == 0)
        begin
            tests_passed++;
            $display("reset: hi and lo zero ok");
        end
        else
        begin
            tests_failed++;
            $display("reset: hi and lo not zero FAIL");
        end

        // one pair per cycle, each result due two edges later
        while (issued < stim_q.size() || pending_q.size() > 0)
        begin
            if (issued < stim_q.size())
            begin
                cur = stim_q[issued];
                cur.issue = cycle;
                a = cur.a;
                b = cur.b;
                pending_q.push_back(cur);
                issued++;
            end
            else
            begin
                a = '0;
                b = '0;
            end
            @(posedge clk);
            #1;
            if (pending_q.size() > 0 && pending_q[0].issue + 2 == cycle)
            begin
                cur = pending_q.pop_front();
                done_count++;
                finish_case(cur, done_count);
            end
        end

        $display("tests: %0d passed, %0d failed, %0d value errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* mul_top.sv */
`timescale 1ns/1ps

module mul_top (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output mul_pkg::operand_t hi,
    output mul_pkg::operand_t lo
);

    mul_pkg::operand_t a_q;
    mul_pkg::operand_t b_q;
    logic [mul_pkg::product_w-1:0] row_sum;
    logic [mul_pkg::product_w-1:0] row_carry;
    mul_pkg::product_u product;

    operand_capture u_capture (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .b     (b),
        .a_q   (a_q),
        .b_q   (b_q)
    );

    dadda_tree u_tree (
        .a_q       (a_q),
        .b_q       (b_q),
        .row_sum   (row_sum),
        .row_carry (row_carry)
    );

    product_adder u_adder (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_sum   (row_sum),
        .row_carry (row_carry),
        .product   (product)
    );

    // hi is half 1, lo is half 0
    assign hi = product.half[1];
    assign lo = product.half[0];

endmodule

/* product_adder.sv */
`timescale 1ns/1ps

module product_adder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mul_pkg::product_w-1:0]   row_sum,
    input  logic [mul_pkg::product_w-1:0]   row_carry,
    output mul_pkg::product_u               product
);

    // one extra bit to expose the carry out of bit 63
    logic [mul_pkg::product_w:0] sum_ext;

    assign sum_ext = {1'b0, row_sum} + {1'b0, row_carry};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            product <= '0;
        end
        else
        begin
            product.full <= sum_ext[mul_pkg::product_w-1:0];
        end
    end

    // the two rows of a 32x32 product must never overflow 64 bits
    no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) !sum_ext[mul_pkg::product_w]
    )
        else $error("product_adder: carry out of bit 63, reduction tree is wrong");

endmodule

/* dadda_tree.sv */
`timescale 1ns/1ps

module dadda_tree (
    input  mul_pkg::operand_t               a_q,
    input  mul_pkg::operand_t               b_q,
    output logic [mul_pkg::product_w-1:0]   row_sum,
    output logic [mul_pkg::product_w-1:0]   row_carry
);

    // raw partial products, packed from bit 0 of each column
    logic [mul_pkg::max_height-1:0] pp [mul_pkg::col_count];

    for (genvar w = 0; w < mul_pkg::col_count; w++)
    begin : g_pp
        localparam int lo_j = (w < mul_pkg::operand_w) ? 0 : w - mul_pkg::operand_w + 1;
        localparam int n    = mul_pkg::pp_height(w);

        for (genvar k = 0; k < n; k++)
        begin : g_and
            assign pp[w][k] = a_q[w-lo_j-k] & b_q[lo_j+k];
        end

        for (genvar k = n; k < mul_pkg::max_height; k++)
        begin : g_zero
            assign pp[w][k] = 1'b0;
        end
    end

    // eight stages, each one narrower than the last
    for (genvar s = 0; s < mul_pkg::stage_count; s++)
    begin : g_stage
        localparam int lim  = mul_pkg::dadda_limits[s];
        localparam int in_h = (s == 0) ? mul_pkg::max_height
                                       : mul_pkg::dadda_limits[(s > 0) ? s - 1 : 0];

        logic [lim-1:0] cols [mul_pkg::col_count];

        if (s == 0)
        begin : g_first
            dadda_stage #(
                .limit     (lim),
                .in_height (in_h)
            ) u_stage (
                .cols_in  (pp),
                .cols_out (cols)
            );
        end
        else
        begin : g_next
            dadda_stage #(
                .limit     (lim),
                .in_height (in_h)
            ) u_stage (
                .cols_in  (g_stage[s-1].cols),
                .cols_out (cols)
            );
        end
    end

    for (genvar w = 0; w < mul_pkg::col_count; w++)
    begin : g_rows
        assign row_sum[w]   = g_stage[mul_pkg::stage_count-1].cols[w][0];
        assign row_carry[w] = g_stage[mul_pkg::stage_count-1].cols[w][1];
    end

    // no partial product reaches weight 63
    assign row_sum[mul_pkg::product_w-1]   = 1'b0;
    assign row_carry[mul_pkg::product_w-1] = 1'b0;

endmodule

/* dadda_stage.sv */
`timescale 1ns/1ps

module dadda_stage #(
    parameter int limit     = 2,
    parameter int in_height = 3
) (
    input  logic [in_height-1:0] cols_in  [mul_pkg::col_count],
    output logic [limit-1:0]     cols_out [mul_pkg::col_count]
);

    // carries leaving each column, picked up by the one above
    logic [in_height-1:0] carry_out [mul_pkg::col_count];

    for (genvar w = 0; w < mul_pkg::col_count; w++)
    begin : g_col
        localparam int h     = mul_pkg::dadda_col(limit, w, 0);
        localparam int c_in  = mul_pkg::dadda_col(limit, w, 1);
        localparam int n_fa  = mul_pkg::dadda_col(limit, w, 2);
        localparam int n_ha  = mul_pkg::dadda_col(limit, w, 3);
        localparam int used  = 3 * n_fa + 2 * n_ha;
        localparam int base  = n_fa + n_ha;
        localparam int pass  = h - used;
        localparam int fill  = base + pass + c_in;

        // 3:2 cells
        for (genvar k = 0; k < n_fa; k++)
        begin : g_fa
            logic x;
            logic y;
            logic z;
            assign x = cols_in[w][3*k];
            assign y = cols_in[w][3*k+1];
            assign z = cols_in[w][3*k+2];
            assign cols_out[w][k] = x ^ y ^ z;
            assign carry_out[w][k] = (x & y) | (z & (x ^ y));
        end

        // 2:2 cells after the full adders
        for (genvar k = 0; k < n_ha; k++)
        begin : g_ha
            logic x;
            logic y;
            assign x = cols_in[w][3*n_fa+2*k];
            assign y = cols_in[w][3*n_fa+2*k+1];
            assign cols_out[w][n_fa+k] = x ^ y;
            assign carry_out[w][n_fa+k] = x & y;
        end

        for (genvar k = base; k < in_height; k++)
        begin : g_carry_zero
            assign carry_out[w][k] = 1'b0;
        end

        // bits left untouched drop straight through
        for (genvar k = 0; k < pass; k++)
        begin : g_pass
            assign cols_out[w][base+k] = cols_in[w][used+k];
        end

        // carries from the column below sit on top
        for (genvar k = 0; k < c_in; k++)
        begin : g_cin
            assign cols_out[w][base+pass+k] = carry_out[w-1][k];
        end

        for (genvar k = fill; k < limit; k++)
        begin : g_zero
            assign cols_out[w][k] = 1'b0;
        end
    end

endmodule

/* operand_capture.sv */
`timescale 1ns/1ps

module operand_capture (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output mul_pkg::operand_t a_q,
    output mul_pkg::operand_t b_q
);

    // a fresh pair is taken on every edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            a_q <= '0;
            b_q <= '0;
        end
        else
        begin
            a_q <= a;
            b_q <= b;
        end
    end

    // unknown operand bits would spread through the whole tree
    operands_known: assert property (
        @(posedge clk) rst_n |-> !$isunknown({a, b})
    )
        else $error("operand_capture: unknown bits on a or b");

endmodule

/* mul_pkg.sv */
package mul_pkg;

    localparam int operand_w = 32;
    localparam int product_w = 2 * operand_w;
    // weights 0 .. 62 carry partial products
    localparam int col_count = product_w - 1;
    localparam int max_height = operand_w;
    localparam int stage_count = 8;

    // height limit reached after each reduction stage
    localparam int dadda_limits [stage_count] = '{28, 19, 13, 9, 6, 4, 3, 2};

    typedef logic [operand_w-1:0] operand_t;

    // product seen whole or as hi/lo words
    typedef union packed {
        logic [product_w-1:0] full;
        operand_t [1:0]       half;
    } product_u;

    // bits in column w of the raw partial-product triangle
    function automatic int pp_height(int w);
        return (w < operand_w) ? w + 1 : col_count - w;
    endfunction

    // schedule of the stage that reduces to lim, for column w
    // sel 0 returns the incoming height, 1 the carries in, 2 full adders, 3 half adders
    function automatic int dadda_col(int lim, int w, int sel);
        int h [col_count];
        int c;
        int tot;
        int ex;
        int nf;
        int nh;
        int res;
        res = 0;
        for (int i = 0; i < col_count; i++)
            h[i] = pp_height(i);
        // replay every stage that runs ahead of this one
        for (int s = 0; s < stage_count; s++)
        begin
            if (dadda_limits[s] > lim)
            begin
                c = 0;
                for (int i = 0; i < col_count; i++)
                begin
                    tot = h[i] + c;
                    ex = (tot > dadda_limits[s]) ? tot - dadda_limits[s] : 0;
                    nf = ex / 2;
                    nh = ex % 2;
                    h[i] = tot - 2 * nf - nh;
                    c = nf + nh;
                end
            end
        end
        // walk this stage from weight 0 up to column w
        c = 0;
        for (int i = 0; i <= w; i++)
        begin
            tot = h[i] + c;
            ex = (tot > lim) ? tot - lim : 0;
            nf = ex / 2;
            nh = ex % 2;
            if (i == w)
            begin
                case (sel)
                    0: res = h[i];
                    1: res = c;
                    2: res = nf;
                    default: res = nh;
                endcase
            end
            c = nf + nh;
        end
        return res;
    endfunction

endpackage
